//--- logic/fpu_pkg.sv
// shared by the FP slice; compare logic only holds for 64-bit IEEE-754 doubles
package fpu_pkg;

  // operand and result width, one IEEE double or two packed singles
  localparam int data_w = 64;

  // compare flag vector
  localparam int flag_w  = 4;
  localparam int flag_lt = 0;
  localparam int flag_eq = 1;
  localparam int flag_gt = 2;
  localparam int flag_un = 3;

  // operations understood by the slice
  typedef enum logic [3:0] {
    op_and       = 4'd0,
    op_or        = 4'd1,
    op_xor       = 4'd2,
    op_andn      = 4'd3,
    op_pswap     = 4'd4,
    op_pdup_lo   = 4'd5,
    // ordered compare also flags quiet NaN as invalid
    op_cmp_ord   = 4'd6,
    op_cmp_unord = 4'd7
  } fpu_op_e;

  // where an operand comes from at issue
  typedef enum logic [1:0] {
    src_port     = 2'd0,
    // forwarding bus as seen in the issue cycle
    src_bus_now  = 2'd1,
    // forwarding bus one cycle before issue
    src_bus_prev = 2'd2
  } operand_src_e;

endpackage

//--- logic/fpu_operand_select.sv
// bus_a and bus_b must stay below num_fwd while en is high; src encoding 3 falls back to the port
`timescale 1ns/1ns

module fpu_operand_select #(
  parameter int num_fwd = 4
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     en,
  input  fpu_pkg::fpu_op_e                         op,
  input  logic [fpu_pkg::data_w-1:0]               a,
  input  logic [fpu_pkg::data_w-1:0]               b,
  input  fpu_pkg::operand_src_e                    src_a,
  input  fpu_pkg::operand_src_e                    src_b,
  input  logic [((num_fwd > 1) ? $clog2(num_fwd) : 1)-1:0] bus_a,
  input  logic [((num_fwd > 1) ? $clog2(num_fwd) : 1)-1:0] bus_b,
  input  logic [num_fwd-1:0][fpu_pkg::data_w-1:0]  fwd_bus,
  output logic                                     sel_valid,
  output fpu_pkg::fpu_op_e                         sel_op,
  output logic [fpu_pkg::data_w-1:0]               sel_a,
  output logic [fpu_pkg::data_w-1:0]               sel_b
);

  localparam int idx_w = (num_fwd > 1) ? $clog2(num_fwd) : 1;

  logic [num_fwd-1:0][fpu_pkg::data_w-1:0] fwd_prev;
  logic [fpu_pkg::data_w-1:0]              opnd_a;
  logic [fpu_pkg::data_w-1:0]              opnd_b;

  // one operand mux, shared by A and B
  function automatic logic [fpu_pkg::data_w-1:0] pick_operand(
    input fpu_pkg::operand_src_e                   src,
    input logic [fpu_pkg::data_w-1:0]              port_val,
    input logic [idx_w-1:0]                        idx,
    input logic [num_fwd-1:0][fpu_pkg::data_w-1:0] live,
    input logic [num_fwd-1:0][fpu_pkg::data_w-1:0] prev
  );
    logic [fpu_pkg::data_w-1:0] val;
    case (src)
      fpu_pkg::src_bus_now:  val = live[idx];
      fpu_pkg::src_bus_prev: val = prev[idx];
      default:               val = port_val;
    endcase
    return val;
  endfunction

  // every bus is sampled each edge so a late consumer can still see it
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_prev <= '0;
    end else begin
      fwd_prev <= fwd_bus;
    end
  end

  always_comb begin
    opnd_a = pick_operand(src_a, a, bus_a, fwd_bus, fwd_prev);
    opnd_b = pick_operand(src_b, b, bus_b, fwd_bus, fwd_prev);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sel_valid <= 1'b0;
    end else begin
      sel_valid <= en;
    end
  end

  // payload loads only on issue
  always_ff @(posedge clk) begin
    if (en) begin
      sel_op <= op;
      sel_a  <= opnd_a;
      sel_b  <= opnd_b;
    end
  end

  // forwarding index must name a real bus
  a_bus_idx_range: assert property (
    @(posedge clk) disable iff (rst)
    en |-> ((int'(bus_a) < num_fwd) && (int'(bus_b) < num_fwd))
  ) else $error("forwarding bus index out of range");

endmodule

//--- logic/fpu_stage_buffer.sv
// single staging register with no stall input; operands are only meaningful while stg_valid is high
`timescale 1ns/1ns

module fpu_stage_buffer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       sel_valid,
  input  fpu_pkg::fpu_op_e           sel_op,
  input  logic [fpu_pkg::data_w-1:0] sel_a,
  input  logic [fpu_pkg::data_w-1:0] sel_b,
  output logic                       stg_valid,
  output fpu_pkg::fpu_op_e           stg_op,
  output logic [fpu_pkg::data_w-1:0] stg_a,
  output logic [fpu_pkg::data_w-1:0] stg_b
);

  // valid tracks every cycle so bubbles pass through
  always_ff @(posedge clk) begin
    if (rst) begin
      stg_valid <= 1'b0;
    end else begin
      stg_valid <= sel_valid;
    end
  end

  // operands and opcode hold while idle to save toggles
  always_ff @(posedge clk) begin
    if (sel_valid) begin
      stg_op <= sel_op;
      stg_a  <= sel_a;
      stg_b  <= sel_b;
    end
  end

  // issued opcode survives selection and staging intact
  a_stg_op_legal: assert property (
    @(posedge clk) disable iff (rst)
    stg_valid |-> stg_op inside {
      fpu_pkg::op_and,
      fpu_pkg::op_or,
      fpu_pkg::op_xor,
      fpu_pkg::op_andn,
      fpu_pkg::op_pswap,
      fpu_pkg::op_pdup_lo,
      fpu_pkg::op_cmp_ord,
      fpu_pkg::op_cmp_unord
    }
  ) else $error("illegal opcode reached the execution stage");

endmodule

//--- logic/fpu_simd_exec.sv
// doubles only with no denormal flush or rounding; res, cmp_flags and inv_raise hold between results
`timescale 1ns/1ns

module fpu_simd_exec (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       stg_valid,
  input  fpu_pkg::fpu_op_e           stg_op,
  input  logic [fpu_pkg::data_w-1:0] stg_a,
  input  logic [fpu_pkg::data_w-1:0] stg_b,
  input  logic                       inv_enable,
  output logic                       res_valid,
  output logic [fpu_pkg::data_w-1:0] res,
  output logic [fpu_pkg::flag_w-1:0] cmp_flags,
  output logic                       inv_raise,
  output logic                       exc_valid
);

  localparam int half_w = fpu_pkg::data_w / 2;

  logic                       any_nan;
  logic                       any_snan;
  logic                       both_zero;
  logic                       a_eq_b;
  logic                       a_lt_b;
  logic [fpu_pkg::data_w-2:0] mag_a;
  logic [fpu_pkg::data_w-2:0] mag_b;
  logic [fpu_pkg::data_w-1:0] res_next;
  logic [fpu_pkg::flag_w-1:0] flags_next;
  logic                       inv_next;

  // exponent all ones with a nonzero fraction
  function automatic logic is_nan(input logic [fpu_pkg::data_w-1:0] x);
    return (&x[62:52]) && (|x[51:0]);
  endfunction

  // signalling NaN has the quiet bit clear
  function automatic logic is_snan(input logic [fpu_pkg::data_w-1:0] x);
    return is_nan(x) && !x[51];
  endfunction

  // classify and order the two doubles
  always_comb begin
    mag_a     = stg_a[fpu_pkg::data_w-2:0];
    mag_b     = stg_b[fpu_pkg::data_w-2:0];
    any_nan   = is_nan(stg_a) || is_nan(stg_b);
    any_snan  = is_snan(stg_a) || is_snan(stg_b);
    // sign is ignored for zero
    both_zero = (mag_a == '0) && (mag_b == '0);
    a_eq_b    = both_zero || (stg_a == stg_b);
    if (stg_a[fpu_pkg::data_w-1] != stg_b[fpu_pkg::data_w-1]) begin
      a_lt_b = stg_a[fpu_pkg::data_w-1];
    end else if (!stg_a[fpu_pkg::data_w-1]) begin
      a_lt_b = mag_a < mag_b;
    end else begin
      // both negative, larger magnitude is smaller
      a_lt_b = mag_a > mag_b;
    end
  end

  always_comb begin
    res_next   = '0;
    flags_next = '0;
    inv_next   = 1'b0;
    case (stg_op)
      fpu_pkg::op_and:     res_next = stg_a & stg_b;
      fpu_pkg::op_or:      res_next = stg_a | stg_b;
      fpu_pkg::op_xor:     res_next = stg_a ^ stg_b;
      fpu_pkg::op_andn:    res_next = stg_a & ~stg_b;
      fpu_pkg::op_pswap:   res_next = {stg_a[half_w-1:0], stg_a[fpu_pkg::data_w-1:half_w]};
      fpu_pkg::op_pdup_lo: res_next = {stg_b[half_w-1:0], stg_b[half_w-1:0]};
      fpu_pkg::op_cmp_ord, fpu_pkg::op_cmp_unord: begin
        if (any_nan) begin
          flags_next[fpu_pkg::flag_un] = 1'b1;
        end else if (a_eq_b) begin
          flags_next[fpu_pkg::flag_eq] = 1'b1;
        end else if (a_lt_b) begin
          flags_next[fpu_pkg::flag_lt] = 1'b1;
        end else begin
          flags_next[fpu_pkg::flag_gt] = 1'b1;
        end
        inv_next = any_snan || (any_nan && (stg_op == fpu_pkg::op_cmp_ord));
      end
      default: res_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      exc_valid <= 1'b0;
    end else begin
      res_valid <= stg_valid;
      // report only what software lets through
      exc_valid <= stg_valid && inv_next && inv_enable;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res       <= '0;
      cmp_flags <= '0;
      inv_raise <= 1'b0;
    end else if (stg_valid) begin
      res       <= res_next;
      cmp_flags <= flags_next;
      inv_raise <= inv_next;
    end
  end

  // exception reports ride on a result
  a_exc_with_result: assert property (
    @(posedge clk) disable iff (rst)
    exc_valid |-> (res_valid && inv_raise)
  ) else $error("exception report without a matching result");

endmodule

//--- logic/fpu_unit.sv
// three-stage slice with no stall path; a result appears exactly three cycles after en
`timescale 1ns/1ns

module fpu_unit #(
  parameter int num_fwd = 4
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     en,
  input  fpu_pkg::fpu_op_e                         op,
  input  logic [fpu_pkg::data_w-1:0]               a,
  input  logic [fpu_pkg::data_w-1:0]               b,
  input  fpu_pkg::operand_src_e                    src_a,
  input  fpu_pkg::operand_src_e                    src_b,
  input  logic [((num_fwd > 1) ? $clog2(num_fwd) : 1)-1:0] bus_a,
  input  logic [((num_fwd > 1) ? $clog2(num_fwd) : 1)-1:0] bus_b,
  input  logic [num_fwd-1:0][fpu_pkg::data_w-1:0]  fwd_bus,
  input  logic                                     inv_enable,
  output logic                                     res_valid,
  output logic [fpu_pkg::data_w-1:0]               res,
  output logic [fpu_pkg::flag_w-1:0]               cmp_flags,
  output logic                                     inv_raise,
  output logic                                     exc_valid
);

  // selection to staging
  logic                       sel_valid;
  fpu_pkg::fpu_op_e           sel_op;
  logic [fpu_pkg::data_w-1:0] sel_a;
  logic [fpu_pkg::data_w-1:0] sel_b;

  // staging to execution
  logic                       stg_valid;
  fpu_pkg::fpu_op_e           stg_op;
  logic [fpu_pkg::data_w-1:0] stg_a;
  logic [fpu_pkg::data_w-1:0] stg_b;

  fpu_operand_select #(
    .num_fwd(num_fwd)
  ) i_operand_select (
    .clk(clk), .rst(rst), .en(en), .op(op), .a(a), .b(b),
    .src_a(src_a), .src_b(src_b), .bus_a(bus_a), .bus_b(bus_b), .fwd_bus(fwd_bus),
    .sel_valid(sel_valid), .sel_op(sel_op), .sel_a(sel_a), .sel_b(sel_b)
  );

  fpu_stage_buffer i_stage_buffer (
    .clk(clk), .rst(rst),
    .sel_valid(sel_valid), .sel_op(sel_op), .sel_a(sel_a), .sel_b(sel_b),
    .stg_valid(stg_valid), .stg_op(stg_op), .stg_a(stg_a), .stg_b(stg_b)
  );

  fpu_simd_exec i_simd_exec (
    .clk(clk), .rst(rst),
    .stg_valid(stg_valid), .stg_op(stg_op), .stg_a(stg_a), .stg_b(stg_b),
    .inv_enable(inv_enable),
    .res_valid(res_valid), .res(res), .cmp_flags(cmp_flags),
    .inv_raise(inv_raise), .exc_valid(exc_valid)
  );

endmodule

//--- verification/fpu_model.svh
// included inside the testbench module; assumes 64-bit IEEE-754 doubles and the fpu_pkg opcodes
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// exponent saturated, fraction nonzero
function automatic bit model_is_nan(input logic [63:0] x);
  return (x[62:52] == 11'h7ff) && (x[51:0] != 52'd0);
endfunction

// quiet bit is the top fraction bit
function automatic bit model_is_snan(input logic [63:0] x);
  return model_is_nan(x) && (x[51] == 1'b0);
endfunction

// unsigned key with the same numeric order as the double
function automatic logic [63:0] order_key(input logic [63:0] x);
  logic [63:0] key;
  if (x[63]) begin
    key = ~x;
  end else begin
    key = x ^ 64'h8000_0000_0000_0000;
  end
  return key;
endfunction

function automatic bit model_is_cmp(input fpu_pkg::fpu_op_e op);
  return (op == fpu_pkg::op_cmp_ord) || (op == fpu_pkg::op_cmp_unord);
endfunction

function automatic logic [63:0] model_result(input fpu_pkg::fpu_op_e op,
                                             input logic [63:0] a, input logic [63:0] b);
  case (op)
    fpu_pkg::op_and:     return a & b;
    fpu_pkg::op_or:      return a | b;
    fpu_pkg::op_xor:     return a ^ b;
    fpu_pkg::op_andn:    return a & ~b;
    fpu_pkg::op_pswap:   return {a[31:0], a[63:32]};
    fpu_pkg::op_pdup_lo: return {b[31:0], b[31:0]};
    default:             return 64'd0;
  endcase
endfunction

function automatic logic [3:0] model_flags(input fpu_pkg::fpu_op_e op,
                                           input logic [63:0] a, input logic [63:0] b);
  logic [3:0] f;
  f = 4'd0;
  if (model_is_cmp(op)) begin
    if (model_is_nan(a) || model_is_nan(b)) begin
      f[fpu_pkg::flag_un] = 1'b1;
    end else if ((a[62:0] == 63'd0 && b[62:0] == 63'd0) || a == b) begin
      // +0 and -0 compare equal
      f[fpu_pkg::flag_eq] = 1'b1;
    end else if (order_key(a) < order_key(b)) begin
      f[fpu_pkg::flag_lt] = 1'b1;
    end else begin
      f[fpu_pkg::flag_gt] = 1'b1;
    end
  end
  return f;
endfunction

function automatic bit model_invalid(input fpu_pkg::fpu_op_e op,
                                     input logic [63:0] a, input logic [63:0] b);
  bit nan_in;
  nan_in = model_is_nan(a) || model_is_nan(b);
  if (!model_is_cmp(op)) return 1'b0;
  if (model_is_snan(a) || model_is_snan(b)) return 1'b1;
  return nan_in && (op == fpu_pkg::op_cmp_ord);
endfunction

`endif

//--- verification/fpu_unit_tb.sv
// runs fpu_unit with num_fwd of 4; expects every result exactly three cycles after issue
`timescale 1ns/1ns

module fpu_unit_tb;

  localparam int num_fwd     = 4;
  localparam int idx_w       = 2;
  localparam int drain_limit = 20;

  logic                     clk;
  logic                     rst;
  logic                     en;
  fpu_pkg::fpu_op_e         op;
  logic [63:0]              a;
  logic [63:0]              b;
  fpu_pkg::operand_src_e    src_a;
  fpu_pkg::operand_src_e    src_b;
  logic [idx_w-1:0]         bus_a;
  logic [idx_w-1:0]         bus_b;
  logic [num_fwd-1:0][63:0] fwd_bus;
  logic                     inv_enable;
  logic                     res_valid;
  logic [63:0]              res;
  logic [3:0]               cmp_flags;
  logic                     inv_raise;
  logic                     exc_valid;

  // bus values the DUT holds as its previous-cycle copy
  logic [num_fwd-1:0][63:0] fwd_last;
  // expected results, index 2 is due at the next check
  logic                     pipe_v     [0:2];
  logic [63:0]              pipe_res   [0:2];
  logic [3:0]               pipe_flags [0:2];
  logic                     pipe_inv   [0:2];
  int                       checks;
  int                       errors;
  int                       err_mark;
  int                       issued;
  int                       results;
  bit                       quiet_check;
  bit                       inv_random;

  `include "fpu_model.svh"

  fpu_unit #(
    .num_fwd(num_fwd)
  ) i_fpu_unit (
    .clk(clk), .rst(rst), .en(en), .op(op), .a(a), .b(b),
    .src_a(src_a), .src_b(src_b), .bus_a(bus_a), .bus_b(bus_b), .fwd_bus(fwd_bus),
    .inv_enable(inv_enable), .res_valid(res_valid), .res(res), .cmp_flags(cmp_flags),
    .inv_raise(inv_raise), .exc_valid(exc_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    if (res_valid === 1'b1) results++;
    check_value(res_valid, pipe_v[2], "res_valid");
    if (pipe_v[2]) begin
      check_value(res, pipe_res[2], "res");
      check_value(cmp_flags, pipe_flags[2], "cmp_flags");
      check_value(inv_raise, pipe_inv[2], "inv_raise");
      // inv_enable still holds the value sampled on the result edge
      check_value(exc_valid, pipe_inv[2] && inv_enable, "exc_valid");
    end else begin
      check_value(exc_valid, 1'b0, "exc_valid");
    end
    if (quiet_check) begin
      check_value(res, 64'd0, "res before first issue");
      check_value(cmp_flags, 4'd0, "cmp_flags before first issue");
    end
  endtask

  // special values come up about half the time
  function automatic logic [63:0] rand_operand();
    logic [63:0] r;
    r = {$urandom, $urandom};
    case ($urandom % 12)
      0: r = 64'h0000_0000_0000_0000;
      1: r = 64'h8000_0000_0000_0000;
      2: r = 64'h7ff0_0000_0000_0000;
      3: r = 64'hfff0_0000_0000_0000;
      4: r = {r[63], 11'h7ff, 1'b1, r[50:0]};
      5: r = {r[63], 11'h7ff, 1'b0, r[50:1], 1'b1};
      default: r = r;
    endcase
    return r;
  endfunction

  function automatic logic [63:0] resolve_operand(input fpu_pkg::operand_src_e src,
                                                  input logic [63:0] port_val,
                                                  input logic [idx_w-1:0] idx);
    case (src)
      fpu_pkg::src_bus_now:  return fwd_bus[idx];
      fpu_pkg::src_bus_prev: return fwd_last[idx];
      default:               return port_val;
    endcase
  endfunction

  // one clock: check the outputs, then drive the next inputs and advance the model
  task automatic step(input logic issue, input fpu_pkg::fpu_op_e nop,
                      input logic [63:0] na, input logic [63:0] nb,
                      input fpu_pkg::operand_src_e nsa, input fpu_pkg::operand_src_e nsb,
                      input logic [idx_w-1:0] nia, input logic [idx_w-1:0] nib);
    logic [63:0] opa;
    logic [63:0] opb;
    int          i;
    @(negedge clk);
    check_outputs();
    fwd_last = fwd_bus;
    for (i = 0; i < num_fwd; i++) begin
      fwd_bus[i] = rand_operand();
    end
    if (inv_random) inv_enable = $urandom % 2;
    en    = issue;
    op    = nop;
    a     = na;
    b     = nb;
    src_a = nsa;
    src_b = nsb;
    bus_a = nia;
    bus_b = nib;
    opa = resolve_operand(nsa, na, nia);
    opb = resolve_operand(nsb, nb, nib);
    for (i = 2; i > 0; i--) begin
      pipe_v[i]     = pipe_v[i-1];
      pipe_res[i]   = pipe_res[i-1];
      pipe_flags[i] = pipe_flags[i-1];
      pipe_inv[i]   = pipe_inv[i-1];
    end
    pipe_v[0]     = issue;
    pipe_res[0]   = model_result(nop, opa, opb);
    pipe_flags[0] = model_flags(nop, opa, opb);
    pipe_inv[0]   = model_invalid(nop, opa, opb);
    if (issue) issued++;
  endtask

  task automatic idle_step();
    step(1'b0, fpu_pkg::op_and, 64'd0, 64'd0, fpu_pkg::src_port, fpu_pkg::src_port, '0, '0);
  endtask

  task automatic random_issue(input fpu_pkg::fpu_op_e nop, input bit port_only);
    fpu_pkg::operand_src_e sa;
    fpu_pkg::operand_src_e sb;
    logic [63:0]           va;
    logic [63:0]           vb;
    sa = port_only ? fpu_pkg::src_port : fpu_pkg::operand_src_e'($urandom % 3);
    sb = port_only ? fpu_pkg::src_port : fpu_pkg::operand_src_e'($urandom % 3);
    va = rand_operand();
    // equal and sign-flipped pairs for the compares
    case ($urandom % 5)
      0: vb = va;
      1: vb = va ^ 64'h8000_0000_0000_0000;
      default: vb = rand_operand();
    endcase
    step(1'b1, nop, va, vb, sa, sb, idx_w'($urandom), idx_w'($urandom));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((pipe_v[0] || pipe_v[1] || pipe_v[2] || res_valid !== 1'b0) && waited < drain_limit) begin
      idle_step();
      waited++;
    end
    if (pipe_v[0] || pipe_v[1] || pipe_v[2] || res_valid !== 1'b0) begin
      $display("Timeout: results still pending after %0d idle cycles at %0t ns", waited, $time);
      $display("ERRORS FOUND");
      $finish;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    int seed_val;
    int n;
    seed_val   = $urandom(87);
    rst        = 1'b1;
    en         = 1'b0;
    op         = fpu_pkg::op_and;
    a          = '0;
    b          = '0;
    src_a      = fpu_pkg::src_port;
    src_b      = fpu_pkg::src_port;
    bus_a      = '0;
    bus_b      = '0;
    fwd_bus    = '0;
    fwd_last   = '0;
    inv_enable = 1'b1;
    inv_random = 1'b0;
    checks     = 0;
    errors     = 0;
    err_mark   = 0;
    issued     = 0;
    results    = 0;
    for (n = 0; n < 3; n++) begin
      pipe_v[n] = 1'b0;
    end
    quiet_check = 1'b1;
    for (n = 0; n < 8; n++) begin
      @(negedge clk);
      check_outputs();
    end
    rst = 1'b0;
    for (n = 0; n < 6; n++) idle_step();
    quiet_check = 1'b0;
    report_test("reset quietness");

    for (n = 0; n < 30; n++) random_issue(fpu_pkg::fpu_op_e'($urandom % 6), 1'b1);
    drain();
    report_test("logic and permute");

    for (n = 0; n < 40; n++) begin
      random_issue(($urandom % 2) ? fpu_pkg::op_xor : fpu_pkg::op_pswap, 1'b0);
    end
    drain();
    report_test("operand forwarding");

    for (n = 0; n < 40; n++) begin
      random_issue(($urandom % 2) ? fpu_pkg::op_cmp_ord : fpu_pkg::op_cmp_unord, 1'b1);
    end
    drain();
    report_test("compare flags");

    inv_random = 1'b1;
    for (n = 0; n < 40; n++) begin
      random_issue(($urandom % 2) ? fpu_pkg::op_cmp_ord : fpu_pkg::op_cmp_unord, 1'b0);
    end
    drain();
    inv_random = 1'b0;
    inv_enable = 1'b1;
    report_test("invalid and exception gating");

    issued  = 0;
    results = 0;
    for (n = 0; n < 50; n++) random_issue(fpu_pkg::fpu_op_e'($urandom % 8), 1'b0);
    drain();
    check_value(results, issued, "result count");
    report_test("full throughput");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verification
logic/fpu_pkg.sv
logic/fpu_operand_select.sv
logic/fpu_stage_buffer.sv
logic/fpu_simd_exec.sv
logic/fpu_unit.sv
verification/fpu_unit_tb.sv

//--- Bender.yml
package:
  name: fpu_unit

sources:
  - files:
      - logic/fpu_pkg.sv
      - logic/fpu_operand_select.sv
      - logic/fpu_stage_buffer.sv
      - logic/fpu_simd_exec.sv
      - logic/fpu_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/fpu_unit_tb.sv
